//--- exec_pkg.sv
// Shared types for the execute stage; WORD_W is fixed at 32 by the integer and float formats
`default_nettype none

package exec_pkg;

	localparam int WORD_W = 32;

	// Lane operations, encoded in declaration order
	typedef enum logic [4:0]
	{
		OP_ASR,
		OP_LSR,
		OP_LSL,
		OP_COPY,
		OP_OR,
		OP_AND,
		OP_XOR,
		OP_CLZ,
		OP_CTZ,
		OP_IADD,
		OP_ISUB,
		OP_EQUAL,
		OP_NEQUAL,
		OP_SIGTR,
		OP_SIGTE,
		OP_SILT,
		OP_SILTE,
		OP_UIGTR,
		OP_UIGTE,
		OP_UILT,
		OP_UILTE,
		OP_SEXT8,
		OP_SEXT16,
		OP_GETLANE,
		OP_RECIP
	} alu_op_t;

	typedef enum logic [2:0]
	{
		BRANCH_ALL,
		BRANCH_ZERO,
		BRANCH_NOT_ZERO,
		BRANCH_ALWAYS,
		BRANCH_CALL_OFFSET,
		BRANCH_NOT_ALL,
		BRANCH_CALL_REGISTER
	} branch_type_t;

	// Pipe that decode steered the instruction to
	typedef enum logic [1:0]
	{
		PIPE_SCYCLE_ARITH,
		PIPE_MCYCLE_ARITH,
		PIPE_MEM
	} pipe_sel_t;

endpackage

`default_nettype wire

//--- reciprocal_rom.sv
// Combinational 6-bit reciprocal table; entry i is floor(8192 / (64 + i)) mod 64, so entry 0 reads 0
`default_nettype none
`timescale 1ns/1ps

module reciprocal_rom(
	input  wire logic [5:0] significand,
	output logic [5:0]      reciprocal_estimate);

	// Leading one of the result is implied and dropped
	always_comb
	begin
		case (significand)
			6'd0: reciprocal_estimate = 6'd0;
			6'd1: reciprocal_estimate = 6'd62;
			6'd2: reciprocal_estimate = 6'd60;
			6'd3: reciprocal_estimate = 6'd58;
			6'd4: reciprocal_estimate = 6'd56;
			6'd5: reciprocal_estimate = 6'd54;
			6'd6: reciprocal_estimate = 6'd53;
			6'd7: reciprocal_estimate = 6'd51;
			6'd8: reciprocal_estimate = 6'd49;
			6'd9: reciprocal_estimate = 6'd48;
			6'd10: reciprocal_estimate = 6'd46;
			6'd11: reciprocal_estimate = 6'd45;
			6'd12: reciprocal_estimate = 6'd43;
			6'd13: reciprocal_estimate = 6'd42;
			6'd14: reciprocal_estimate = 6'd41;
			6'd15: reciprocal_estimate = 6'd39;
			6'd16: reciprocal_estimate = 6'd38;
			6'd17: reciprocal_estimate = 6'd37;
			6'd18: reciprocal_estimate = 6'd35;
			6'd19: reciprocal_estimate = 6'd34;
			6'd20: reciprocal_estimate = 6'd33;
			6'd21: reciprocal_estimate = 6'd32;
			6'd22: reciprocal_estimate = 6'd31;
			6'd23: reciprocal_estimate = 6'd30;
			6'd24: reciprocal_estimate = 6'd29;
			6'd25: reciprocal_estimate = 6'd28;
			6'd26: reciprocal_estimate = 6'd27;
			6'd27: reciprocal_estimate = 6'd26;
			6'd28: reciprocal_estimate = 6'd25;
			6'd29: reciprocal_estimate = 6'd24;
			6'd30: reciprocal_estimate = 6'd23;
			6'd31: reciprocal_estimate = 6'd22;
			6'd32: reciprocal_estimate = 6'd21;
			6'd33: reciprocal_estimate = 6'd20;
			6'd34: reciprocal_estimate = 6'd19;
			6'd35: reciprocal_estimate = 6'd18;
			6'd36: reciprocal_estimate = 6'd17;
			6'd37: reciprocal_estimate = 6'd17;
			6'd38: reciprocal_estimate = 6'd16;
			6'd39: reciprocal_estimate = 6'd15;
			6'd40: reciprocal_estimate = 6'd14;
			6'd41: reciprocal_estimate = 6'd14;
			6'd42: reciprocal_estimate = 6'd13;
			6'd43: reciprocal_estimate = 6'd12;
			6'd44: reciprocal_estimate = 6'd11;
			6'd45: reciprocal_estimate = 6'd11;
			6'd46: reciprocal_estimate = 6'd10;
			6'd47: reciprocal_estimate = 6'd9;
			6'd48: reciprocal_estimate = 6'd9;
			6'd49: reciprocal_estimate = 6'd8;
			6'd50: reciprocal_estimate = 6'd7;
			6'd51: reciprocal_estimate = 6'd7;
			6'd52: reciprocal_estimate = 6'd6;
			6'd53: reciprocal_estimate = 6'd6;
			6'd54: reciprocal_estimate = 6'd5;
			6'd55: reciprocal_estimate = 6'd4;
			6'd56: reciprocal_estimate = 6'd4;
			6'd57: reciprocal_estimate = 6'd3;
			6'd58: reciprocal_estimate = 6'd3;
			6'd59: reciprocal_estimate = 6'd2;
			6'd60: reciprocal_estimate = 6'd2;
			6'd61: reciprocal_estimate = 6'd1;
			6'd62: reciprocal_estimate = 6'd1;
			6'd63: reciprocal_estimate = 6'd0;
		endcase
	end
endmodule

`default_nettype wire

//--- lane_alu.sv
// One vector lane, combinational; NUM_LANES must be a power of two of at least 2 for GETLANE
`default_nettype none
`timescale 1ns/1ps

module lane_alu
	import exec_pkg::*;
#(
	parameter int NUM_LANES = 16,
	parameter int LANE = 0
)(
	input  wire alu_op_t                         alu_op,
	input  wire logic [NUM_LANES*WORD_W-1:0]     operand1_vector,
	input  wire logic [WORD_W-1:0]               operand2,
	output logic [WORD_W-1:0]                    result);

	localparam int LANE_IDX_W = $clog2(NUM_LANES);

	logic [WORD_W-1:0]     operand1;
	logic [WORD_W-1:0]     difference;
	logic                  borrow;
	logic                  negative;
	logic                  overflow;
	logic                  zero;
	logic                  signed_gtr;
	logic [4:0]            shamt;
	logic [5:0]            lz;
	logic [5:0]            tz;
	logic [LANE_IDX_W-1:0] get_lane;
	logic                  fp_sign;
	logic [7:0]            fp_exponent;
	logic [22:0]           fp_significand;
	logic [5:0]            reciprocal_estimate;
	logic [7:0]            recip_exponent;
	logic [WORD_W-1:0]     reciprocal;

	assign operand1 = operand1_vector[LANE*WORD_W +: WORD_W];

	// Compare flags all come from one widened subtraction
	assign {borrow, difference} = {1'b0, operand1} - {1'b0, operand2};
	assign negative = difference[WORD_W-1];
	assign overflow = operand2[WORD_W-1] == negative
		&& operand1[WORD_W-1] != operand2[WORD_W-1];
	assign zero = difference == '0;
	assign signed_gtr = overflow == negative;

	assign shamt = operand2[4:0];

	// Highest set bit wins, a zero word keeps 32
	always_comb
	begin
		lz = 6'd32;
		for (int i = 0; i < WORD_W; i++)
			if (operand2[i])
				lz = 6'(WORD_W - 1 - i);
	end

	// Lowest set bit wins
	always_comb
	begin
		tz = 6'd32;
		for (int i = WORD_W - 1; i >= 0; i--)
			if (operand2[i])
				tz = 6'(i);
	end

	// Lanes are numbered from the top for lane selection
	assign get_lane = LANE_IDX_W'(NUM_LANES - 1) - operand2[LANE_IDX_W-1:0];

	assign fp_sign = operand2[31];
	assign fp_exponent = operand2[30:23];
	assign fp_significand = operand2[22:0];

	reciprocal_rom rom(
		.significand(fp_significand[22:17]),
		.reciprocal_estimate(reciprocal_estimate));

	// Table entry 0 stands for an exact power of two, which needs one more exponent step
	assign recip_exponent = 8'd253 - fp_exponent + {7'd0, fp_significand[22:17] == 6'd0};

	always_comb
	begin
		if (fp_exponent == 8'd0)
			reciprocal = {fp_sign, 8'hff, 23'd0};
		else if (fp_exponent == 8'hff)
		begin
			if (fp_significand != 23'd0)
				reciprocal = 32'h7fffffff;
			else
				reciprocal = {fp_sign, 31'd0};
		end
		else
			reciprocal = {fp_sign, recip_exponent, reciprocal_estimate, 17'd0};
	end

	always_comb
	begin
		case (alu_op)
			OP_ASR: result = WORD_W'($signed(operand1) >>> shamt);
			OP_LSR: result = operand1 >> shamt;
			OP_LSL: result = operand1 << shamt;
			OP_COPY: result = operand2;
			OP_OR: result = operand1 | operand2;
			OP_AND: result = operand1 & operand2;
			OP_XOR: result = operand1 ^ operand2;
			OP_CLZ: result = {{(WORD_W-6){1'b0}}, lz};
			OP_CTZ: result = {{(WORD_W-6){1'b0}}, tz};
			OP_IADD: result = operand1 + operand2;
			OP_ISUB: result = difference;
			OP_EQUAL: result = {{(WORD_W-1){1'b0}}, zero};
			OP_NEQUAL: result = {{(WORD_W-1){1'b0}}, !zero};
			OP_SIGTR: result = {{(WORD_W-1){1'b0}}, signed_gtr && !zero};
			OP_SIGTE: result = {{(WORD_W-1){1'b0}}, signed_gtr || zero};
			OP_SILT: result = {{(WORD_W-1){1'b0}}, !signed_gtr && !zero};
			OP_SILTE: result = {{(WORD_W-1){1'b0}}, !signed_gtr || zero};
			OP_UIGTR: result = {{(WORD_W-1){1'b0}}, !borrow && !zero};
			OP_UIGTE: result = {{(WORD_W-1){1'b0}}, !borrow || zero};
			OP_UILT: result = {{(WORD_W-1){1'b0}}, borrow && !zero};
			OP_UILTE: result = {{(WORD_W-1){1'b0}}, borrow || zero};
			OP_SEXT8: result = {{(WORD_W-8){operand2[7]}}, operand2[7:0]};
			OP_SEXT16: result = {{(WORD_W-16){operand2[15]}}, operand2[15:0]};
			OP_GETLANE: result = operand1_vector[get_lane*WORD_W +: WORD_W];
			OP_RECIP: result = reciprocal;
			default: result = '0;
		endcase
	end
endmodule

`default_nettype wire

//--- branch_resolve.sv
// Combinational branch decision on lane 0 of operand 1; taken is 0 whenever is_branch is 0
`default_nettype none
`timescale 1ns/1ps

module branch_resolve
	import exec_pkg::*;
(
	input  wire logic              is_branch,
	input  wire branch_type_t      branch_type,
	input  wire logic [WORD_W-1:0] operand1_lane0,
	input  wire logic [WORD_W-1:0] pc,
	input  wire logic [WORD_W-1:0] immediate,
	output logic                   taken,
	output logic [WORD_W-1:0]      target);

	logic all_ones;

	// ALL and NOT_ALL look at the 16-bit lane mask in the low half
	assign all_ones = operand1_lane0[15:0] == 16'hffff;

	// pc already points at the branch, so step past it
	assign target = branch_type == BRANCH_CALL_REGISTER ? operand1_lane0
		: pc + WORD_W'(4) + immediate;

	always_comb
	begin
		if (!is_branch)
			taken = 1'b0;
		else
		begin
			case (branch_type)
				BRANCH_ALL: taken = all_ones;
				BRANCH_NOT_ALL: taken = !all_ones;
				BRANCH_ZERO: taken = operand1_lane0 == '0;
				BRANCH_NOT_ZERO: taken = operand1_lane0 != '0;
				BRANCH_ALWAYS,
				BRANCH_CALL_OFFSET,
				BRANCH_CALL_REGISTER: taken = 1'b1;
				default: taken = 1'b0;
			endcase
		end
	end
endmodule

`default_nettype wire

//--- single_cycle_execute_stage.sv
// One-clock execute stage with no back-pressure; writeback must take every output cycle
`default_nettype none
`timescale 1ns/1ps

module single_cycle_execute_stage
	import exec_pkg::*;
#(
	parameter int NUM_LANES = 16,
	parameter int THREAD_IDX_W = 2,
	parameter int SUBCYCLE_W = 4
)(
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire logic                          of_instruction_valid,
	input  wire logic [NUM_LANES*WORD_W-1:0]   of_operand1,
	input  wire logic [NUM_LANES*WORD_W-1:0]   of_operand2,
	input  wire logic [NUM_LANES-1:0]          of_mask_value,
	input  wire alu_op_t                       of_alu_op,
	input  wire pipe_sel_t                     of_pipe_sel,
	input  wire logic                          of_is_branch,
	input  wire branch_type_t                  of_branch_type,
	input  wire logic [WORD_W-1:0]             of_pc,
	input  wire logic [WORD_W-1:0]             of_immediate,
	input  wire logic [THREAD_IDX_W-1:0]       of_thread_idx,
	input  wire logic [SUBCYCLE_W-1:0]         of_subcycle,
	input  wire logic                          wb_rollback_en,
	input  wire logic [THREAD_IDX_W-1:0]       wb_rollback_thread_idx,
	output logic                               sx_instruction_valid,
	output logic [NUM_LANES*WORD_W-1:0]        sx_result,
	output logic [NUM_LANES-1:0]               sx_mask_value,
	output logic [THREAD_IDX_W-1:0]            sx_thread_idx,
	output logic [SUBCYCLE_W-1:0]              sx_subcycle,
	output logic                               sx_rollback_en,
	output logic [WORD_W-1:0]                  sx_rollback_pc);

	logic [NUM_LANES*WORD_W-1:0] lane_results;
	logic                        branch_taken;
	logic [WORD_W-1:0]           branch_target;
	logic                        accept;

	genvar lane;
	generate
		for (lane = 0; lane < NUM_LANES; lane++)
		begin : lane_gen
			lane_alu #(
				.NUM_LANES(NUM_LANES),
				.LANE(lane)
			) alu(
				.alu_op(of_alu_op),
				.operand1_vector(of_operand1),
				.operand2(of_operand2[lane*WORD_W +: WORD_W]),
				.result(lane_results[lane*WORD_W +: WORD_W]));
		end
	endgenerate

	branch_resolve branch(
		.is_branch(of_is_branch),
		.branch_type(of_branch_type),
		.operand1_lane0(of_operand1[WORD_W-1:0]),
		.pc(of_pc),
		.immediate(of_immediate),
		.taken(branch_taken),
		.target(branch_target));

	// Squash anything for another pipe or for a thread that writeback is rolling back now
	assign accept = of_instruction_valid && of_pipe_sel == PIPE_SCYCLE_ARITH
		&& !(wb_rollback_en && wb_rollback_thread_idx == of_thread_idx);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sx_instruction_valid <= 1'b0;
			sx_rollback_en <= 1'b0;
			sx_result <= '0;
			sx_mask_value <= '0;
			sx_thread_idx <= '0;
			sx_subcycle <= '0;
			sx_rollback_pc <= '0;
		end
		else
		begin
			sx_instruction_valid <= accept;
			sx_rollback_en <= accept && branch_taken;
			sx_result <= lane_results;
			sx_mask_value <= of_mask_value;
			sx_thread_idx <= of_thread_idx;
			sx_subcycle <= of_subcycle;
			sx_rollback_pc <= branch_target;
		end
	end
endmodule

`default_nettype wire

//--- exec_top.sv
// Top level for the execute stage; NUM_LANES must be a power of two, outputs follow inputs by one clock
`default_nettype none
`timescale 1ns/1ps

module exec_top
	import exec_pkg::*;
#(
	parameter int NUM_LANES = 16,
	parameter int THREAD_IDX_W = 2,
	parameter int SUBCYCLE_W = 4
)(
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire logic                          of_instruction_valid,
	input  wire logic [NUM_LANES*WORD_W-1:0]   of_operand1,
	input  wire logic [NUM_LANES*WORD_W-1:0]   of_operand2,
	input  wire logic [NUM_LANES-1:0]          of_mask_value,
	input  wire alu_op_t                       of_alu_op,
	input  wire pipe_sel_t                     of_pipe_sel,
	input  wire logic                          of_is_branch,
	input  wire branch_type_t                  of_branch_type,
	input  wire logic [WORD_W-1:0]             of_pc,
	input  wire logic [WORD_W-1:0]             of_immediate,
	input  wire logic [THREAD_IDX_W-1:0]       of_thread_idx,
	input  wire logic [SUBCYCLE_W-1:0]         of_subcycle,
	input  wire logic                          wb_rollback_en,
	input  wire logic [THREAD_IDX_W-1:0]       wb_rollback_thread_idx,
	output logic                               sx_instruction_valid,
	output logic [NUM_LANES*WORD_W-1:0]        sx_result,
	output logic [NUM_LANES-1:0]               sx_mask_value,
	output logic [THREAD_IDX_W-1:0]            sx_thread_idx,
	output logic [SUBCYCLE_W-1:0]              sx_subcycle,
	output logic                               sx_rollback_en,
	output logic [WORD_W-1:0]                  sx_rollback_pc);

	single_cycle_execute_stage #(
		.NUM_LANES(NUM_LANES),
		.THREAD_IDX_W(THREAD_IDX_W),
		.SUBCYCLE_W(SUBCYCLE_W)
	) stage(
		.clk(clk),
		.reset(reset),
		.of_instruction_valid(of_instruction_valid),
		.of_operand1(of_operand1),
		.of_operand2(of_operand2),
		.of_mask_value(of_mask_value),
		.of_alu_op(of_alu_op),
		.of_pipe_sel(of_pipe_sel),
		.of_is_branch(of_is_branch),
		.of_branch_type(of_branch_type),
		.of_pc(of_pc),
		.of_immediate(of_immediate),
		.of_thread_idx(of_thread_idx),
		.of_subcycle(of_subcycle),
		.wb_rollback_en(wb_rollback_en),
		.wb_rollback_thread_idx(wb_rollback_thread_idx),
		.sx_instruction_valid(sx_instruction_valid),
		.sx_result(sx_result),
		.sx_mask_value(sx_mask_value),
		.sx_thread_idx(sx_thread_idx),
		.sx_subcycle(sx_subcycle),
		.sx_rollback_en(sx_rollback_en),
		.sx_rollback_pc(sx_rollback_pc));
endmodule

`default_nettype wire

//--- tb_exec.sv
// Runs exec_top with 4 lanes on random stimulus; expected values come from an in-file model
`default_nettype none
`timescale 1ns/1ps

module tb_exec;
	import exec_pkg::*;

	localparam int NL = 4;
	localparam int TW = 2;
	localparam int SW = 4;
	localparam int NUM_CYCLES = 2000;
	localparam int MAX_CYCLES = 3000;

	logic                 clk;
	logic                 reset;
	logic                 of_instruction_valid;
	logic [NL*WORD_W-1:0] of_operand1;
	logic [NL*WORD_W-1:0] of_operand2;
	logic [NL-1:0]        of_mask_value;
	alu_op_t              of_alu_op;
	pipe_sel_t            of_pipe_sel;
	logic                 of_is_branch;
	branch_type_t         of_branch_type;
	logic [WORD_W-1:0]    of_pc;
	logic [WORD_W-1:0]    of_immediate;
	logic [TW-1:0]        of_thread_idx;
	logic [SW-1:0]        of_subcycle;
	logic                 wb_rollback_en;
	logic [TW-1:0]        wb_rollback_thread_idx;
	logic                 sx_instruction_valid;
	logic [NL*WORD_W-1:0] sx_result;
	logic [NL-1:0]        sx_mask_value;
	logic [TW-1:0]        sx_thread_idx;
	logic [SW-1:0]        sx_subcycle;
	logic                 sx_rollback_en;
	logic [WORD_W-1:0]    sx_rollback_pc;

	// Expected outputs for the instruction now on the inputs
	logic                 exp_valid;
	logic                 exp_rollback_en;
	logic [NL*WORD_W-1:0] exp_result;
	logic [NL-1:0]        exp_mask;
	logic [TW-1:0]        exp_thread;
	logic [SW-1:0]        exp_subcycle;
	logic [WORD_W-1:0]    exp_rollback_pc;

	int          error_count;
	int          check_count;
	logic [31:0] rng;

	exec_top #(
		.NUM_LANES(NL),
		.THREAD_IDX_W(TW),
		.SUBCYCLE_W(SW)
	) UUT(
		.clk(clk),
		.reset(reset),
		.of_instruction_valid(of_instruction_valid),
		.of_operand1(of_operand1),
		.of_operand2(of_operand2),
		.of_mask_value(of_mask_value),
		.of_alu_op(of_alu_op),
		.of_pipe_sel(of_pipe_sel),
		.of_is_branch(of_is_branch),
		.of_branch_type(of_branch_type),
		.of_pc(of_pc),
		.of_immediate(of_immediate),
		.of_thread_idx(of_thread_idx),
		.of_subcycle(of_subcycle),
		.wb_rollback_en(wb_rollback_en),
		.wb_rollback_thread_idx(wb_rollback_thread_idx),
		.sx_instruction_valid(sx_instruction_valid),
		.sx_result(sx_result),
		.sx_mask_value(sx_mask_value),
		.sx_thread_idx(sx_thread_idx),
		.sx_subcycle(sx_subcycle),
		.sx_rollback_en(sx_rollback_en),
		.sx_rollback_pc(sx_rollback_pc));

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand_word();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Mostly random words, with zero, all ones, negatives and float specials mixed in
	function automatic logic [31:0] pick_operand(input logic [31:0] r, input logic [31:0] w);
		case (r[2:0])
			3'd0: return 32'h0;
			3'd1: return 32'hffffffff;
			3'd2:
			begin
				case (r[4:3])
					2'd0: return {r[5], 8'hff, 23'd0};
					2'd1: return {r[5], 8'hff, (w[22:0] | 23'd1)};
					2'd2: return {r[5], 8'h00, w[22:0]};
					default: return {r[5], w[30:23], 6'd0, w[16:0]};
				endcase
			end
			3'd3: return {1'b1, w[30:0]};
			default: return w;
		endcase
	endfunction

	function automatic logic [31:0] lane_model(input logic [4:0] op,
		input logic [NL*WORD_W-1:0] v1, input logic [31:0] b, input int lane);
		logic [31:0]        a;
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		int                 count;
		int                 idx;
		int                 ex;
		int                 est;
		a = v1[lane*32 +: 32];
		sa = a;
		sb = b;
		case (op)
			OP_ASR: return (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'h0);
			OP_LSR: return a >> b[4:0];
			OP_LSL: return a << b[4:0];
			OP_COPY: return b;
			OP_OR: return a | b;
			OP_AND: return a & b;
			OP_XOR: return a ^ b;
			OP_CLZ:
			begin
				count = 32;
				for (int i = 31; i >= 0; i--)
					if (b[i] && count == 32)
						count = 31 - i;
				return 32'(count);
			end
			OP_CTZ:
			begin
				count = 32;
				for (int i = 0; i < 32; i++)
					if (b[i] && count == 32)
						count = i;
				return 32'(count);
			end
			OP_IADD: return a + b;
			OP_ISUB: return a - b;
			OP_EQUAL: return {31'd0, a == b};
			OP_NEQUAL: return {31'd0, a != b};
			OP_SIGTR: return {31'd0, sa > sb};
			OP_SIGTE: return {31'd0, sa >= sb};
			OP_SILT: return {31'd0, sa < sb};
			OP_SILTE: return {31'd0, sa <= sb};
			OP_UIGTR: return {31'd0, a > b};
			OP_UIGTE: return {31'd0, a >= b};
			OP_UILT: return {31'd0, a < b};
			OP_UILTE: return {31'd0, a <= b};
			OP_SEXT8: return {{24{b[7]}}, b[7:0]};
			OP_SEXT16: return {{16{b[15]}}, b[15:0]};
			OP_GETLANE:
			begin
				count = NL - 1 - int'(b % NL);
				return v1[count*32 +: 32];
			end
			OP_RECIP:
			begin
				if (b[30:23] == 8'd0)
					return {b[31], 8'hff, 23'd0};
				if (b[30:23] == 8'hff)
					return b[22:0] != 23'd0 ? 32'h7fffffff : {b[31], 31'd0};
				idx = b[22:17];
				est = (8192 / (64 + idx)) % 64;
				ex = 253 - int'(b[30:23]) + (idx == 0 ? 1 : 0);
				return {b[31], 8'(ex), 6'(est), 17'd0};
			end
			default: return 32'h0;
		endcase
	endfunction

	task automatic branch_model(input logic is_br, input logic [2:0] bt, input logic [31:0] a,
		input logic [31:0] pc, input logic [31:0] imm, output logic taken,
		output logic [31:0] target);
		target = bt == BRANCH_CALL_REGISTER ? a : pc + 32'd4 + imm;
		taken = 1'b0;
		if (is_br)
		begin
			case (bt)
				BRANCH_ALL: taken = a[15:0] == 16'hffff;
				BRANCH_NOT_ALL: taken = a[15:0] != 16'hffff;
				BRANCH_ZERO: taken = a == 32'h0;
				BRANCH_NOT_ZERO: taken = a != 32'h0;
				BRANCH_ALWAYS,
				BRANCH_CALL_OFFSET,
				BRANCH_CALL_REGISTER: taken = 1'b1;
				default: taken = 1'b0;
			endcase
		end
	endtask

	task automatic check_value(input string name, input logic [NL*WORD_W-1:0] got,
		input logic [NL*WORD_W-1:0] expected);
		check_count++;
		assert (got === expected)
		else
		begin
			error_count++;
			$display("ERR %s got %0h expected %0h", name, got, expected);
		end
	endtask

	// Model the instruction currently on the inputs
	task automatic predict();
		logic taken;
		logic [31:0] target;
		exp_valid = of_instruction_valid && of_pipe_sel == PIPE_SCYCLE_ARITH
			&& !(wb_rollback_en && wb_rollback_thread_idx == of_thread_idx);
		branch_model(of_is_branch, of_branch_type, of_operand1[31:0], of_pc, of_immediate,
			taken, target);
		for (int l = 0; l < NL; l++)
			exp_result[l*32 +: 32] = lane_model(of_alu_op, of_operand1, of_operand2[l*32 +: 32], l);
		exp_rollback_en = exp_valid && taken;
		exp_rollback_pc = target;
		exp_mask = of_mask_value;
		exp_thread = of_thread_idx;
		exp_subcycle = of_subcycle;
	endtask

	task automatic compare();
		check_value("sx_instruction_valid", sx_instruction_valid, exp_valid);
		check_value("sx_rollback_en", sx_rollback_en, exp_rollback_en);
		check_value("sx_rollback_pc", sx_rollback_pc, exp_rollback_pc);
		check_value("sx_result", sx_result, exp_result);
		check_value("sx_mask_value", sx_mask_value, exp_mask);
		check_value("sx_thread_idx", sx_thread_idx, exp_thread);
		check_value("sx_subcycle", sx_subcycle, exp_subcycle);
	endtask

	task automatic drive_random();
		logic [31:0]          r;
		logic [NL*WORD_W-1:0] v1;
		logic [NL*WORD_W-1:0] v2;
		r = rand_word();
		for (int l = 0; l < NL; l++)
		begin
			v1[l*32 +: 32] = pick_operand(rand_word(), rand_word());
			v2[l*32 +: 32] = pick_operand(rand_word(), rand_word());
		end
		of_instruction_valid <= r[3:0] != 4'd0;
		of_pipe_sel <= r[5:4] != 2'd0 ? PIPE_SCYCLE_ARITH : (r[6] ? PIPE_MEM : PIPE_MCYCLE_ARITH);
		of_alu_op <= alu_op_t'(r[12:8]);
		of_is_branch <= r[13];
		of_branch_type <= branch_type_t'(r[16:14]);
		of_thread_idx <= r[18:17];
		of_subcycle <= r[22:19];
		wb_rollback_en <= r[24:23] == 2'd3;
		wb_rollback_thread_idx <= r[26:25];
		of_mask_value <= r[30:27];
		of_operand1 <= v1;
		of_operand2 <= v2;
		of_pc <= rand_word() & 32'hfffffffc;
		of_immediate <= rand_word();
	endtask

	initial
	begin
		rng = 32'ha301;
		error_count = 0;
		check_count = 0;
		reset = 1'b1;
		of_instruction_valid = 1'b0;
		of_operand1 = '0;
		of_operand2 = '0;
		of_mask_value = '0;
		of_alu_op = OP_ASR;
		of_pipe_sel = PIPE_SCYCLE_ARITH;
		of_is_branch = 1'b0;
		of_branch_type = BRANCH_ALL;
		of_pc = '0;
		of_immediate = '0;
		of_thread_idx = '0;
		of_subcycle = '0;
		wb_rollback_en = 1'b0;
		wb_rollback_thread_idx = '0;

		// All outputs are cleared while reset is held
		repeat (15) @(posedge clk);
		@(negedge clk);
		check_value("sx_instruction_valid", sx_instruction_valid, '0);
		check_value("sx_rollback_en", sx_rollback_en, '0);
		check_value("sx_result", sx_result, '0);
		check_value("sx_rollback_pc", sx_rollback_pc, '0);
		check_value("sx_mask_value", sx_mask_value, '0);
		check_value("sx_thread_idx", sx_thread_idx, '0);
		check_value("sx_subcycle", sx_subcycle, '0);
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		predict();

		// A few idle cycles first, then one random instruction per clock
		for (int n = 0; n < NUM_CYCLES; n++)
		begin
			@(posedge clk);
			if (n >= 4)
				drive_random();
			@(negedge clk);
			compare();
			predict();
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		for (int c = 0; c < MAX_CYCLES; c++)
			@(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Verification failed");
		$finish;
	end
endmodule

`default_nettype wire

//--- tb.f
exec_pkg.sv
reciprocal_rom.sv
lane_alu.sv
branch_resolve.sv
single_cycle_execute_stage.sv
exec_top.sv
tb_exec.sv
